//--- ex_pkg.sv
package ex_pkg;

    // datapath widths
    localparam int xlen = 64;
    localparam int word_width = 32;
    // shift amount bits for 64-bit and word shifts
    localparam int shamt_width = $clog2(xlen);
    localparam int shamt_word_width = $clog2(word_width);

    typedef logic [23:0] op_code_t;

    // upper immediate and jal
    localparam op_code_t op_lui = 24'h000100;
    localparam op_code_t op_auipc = 24'h000200;
    localparam op_code_t op_jal = 24'h000300;
    // immediate shifts
    localparam op_code_t op_slli = 24'h000400;
    localparam op_code_t op_srli = 24'h000800;
    localparam op_code_t op_srai = 24'h000c00;
    // register ops
    localparam op_code_t op_add = 24'h004000;
    localparam op_code_t op_sub = 24'h005000;
    localparam op_code_t op_sll = 24'h006000;
    localparam op_code_t op_slt = 24'h007000;
    localparam op_code_t op_sltu = 24'h008000;
    localparam op_code_t op_xor = 24'h009000;
    localparam op_code_t op_srl = 24'h010000;
    localparam op_code_t op_or = 24'h012000;
    localparam op_code_t op_and = 24'h013000;
    // word ops
    localparam op_code_t op_slliw = 24'h014000;
    localparam op_code_t op_srliw = 24'h015000;
    localparam op_code_t op_sraiw = 24'h016000;
    localparam op_code_t op_addw = 24'h017000;
    localparam op_code_t op_subw = 24'h018000;
    localparam op_code_t op_sllw = 24'h019000;
    localparam op_code_t op_srlw = 24'h01a000;
    localparam op_code_t op_sraw = 24'h01b000;
    localparam op_code_t op_addiw = 24'd47;
    // jalr and branches
    localparam op_code_t op_jalr = 24'd4;
    localparam op_code_t op_beq = 24'd5;
    localparam op_code_t op_bne = 24'd6;
    localparam op_code_t op_blt = 24'd7;
    localparam op_code_t op_bge = 24'd8;
    localparam op_code_t op_bltu = 24'd9;
    localparam op_code_t op_bgeu = 24'd10;
    // immediate arithmetic
    localparam op_code_t op_addi = 24'd19;
    localparam op_code_t op_slti = 24'd20;
    localparam op_code_t op_sltiu = 24'd21;
    localparam op_code_t op_xori = 24'd22;
    localparam op_code_t op_ori = 24'd23;
    localparam op_code_t op_andi = 24'd24;
    // csr and trap
    localparam op_code_t op_csrrw = 24'd49;
    localparam op_code_t op_csrrs = 24'd50;
    localparam op_code_t op_ecall = 24'h200000;
    localparam op_code_t op_mret = 24'h500000;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra
    } alu_mode_t;

    // what the result step does with alu_y
    typedef enum logic [3:0] {
        rk_alu, rk_word_lo, rk_word_hi, rk_jal, rk_jalr,
        rk_beq, rk_bne, rk_blt, rk_bge,
        rk_csrrw, rk_csrrs, rk_ecall, rk_mret, rk_none
    } res_kind_t;

    // machine csr addresses
    localparam logic [11:0] csr_mtvec = 12'h305;
    localparam logic [11:0] csr_mepc = 12'h341;
    localparam logic [11:0] csr_mcause = 12'h342;
    localparam logic [11:0] csr_mstatus = 12'h300;

    // environment call from m-mode
    localparam logic [xlen-1:0] cause_ecall = 64'd11;
    localparam logic [xlen-1:0] inst_bytes = 64'd4;

endpackage

//--- ex_alu.sv
`timescale 1ns/100ps

module ex_alu (
    input  logic [ex_pkg::xlen-1:0]     alu_a,
    input  logic [ex_pkg::xlen-1:0]     alu_b,
    input  ex_pkg::alu_mode_t           alu_mode,
    output logic [ex_pkg::xlen-1:0]     alu_y
);

    localparam int xl = ex_pkg::xlen;

    logic [ex_pkg::shamt_width-1:0] shamt;
    logic lt_s;
    logic lt_u;

    assign shamt = alu_b[ex_pkg::shamt_width-1:0];
    // compares for slt and the ordered branches
    assign lt_s = $signed(alu_a) < $signed(alu_b);
    assign lt_u = alu_a < alu_b;

    always_comb begin
        case (alu_mode)
            ex_pkg::alu_add: alu_y = alu_a + alu_b;
            // also the equality test for beq and bne
            ex_pkg::alu_sub: alu_y = alu_a - alu_b;
            ex_pkg::alu_slt: alu_y = {{(xl - 1){1'b0}}, lt_s};
            ex_pkg::alu_sltu: alu_y = {{(xl - 1){1'b0}}, lt_u};
            ex_pkg::alu_and: alu_y = alu_a & alu_b;
            ex_pkg::alu_or: alu_y = alu_a | alu_b;
            ex_pkg::alu_xor: alu_y = alu_a ^ alu_b;
            ex_pkg::alu_sll: alu_y = alu_a << shamt;
            ex_pkg::alu_srl: alu_y = alu_a >> shamt;
            ex_pkg::alu_sra: alu_y = $signed(alu_a) >>> shamt;
            default: alu_y = '0;
        endcase
    end

endmodule

//--- ex_decode.sv
`timescale 1ns/100ps

module ex_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic [ex_pkg::xlen-1:0]     in_pc,
    input  ex_pkg::op_code_t            in_op,
    input  logic [ex_pkg::xlen-1:0]     in_src_a,
    input  logic [ex_pkg::xlen-1:0]     in_src_b,
    input  logic [ex_pkg::xlen-1:0]     in_imm,
    output logic                        d_valid,
    output logic [ex_pkg::xlen-1:0]     d_pc,
    output logic [ex_pkg::xlen-1:0]     d_src_a,
    output logic [ex_pkg::xlen-1:0]     d_imm,
    output logic [ex_pkg::xlen-1:0]     alu_a,
    output logic [ex_pkg::xlen-1:0]     alu_b,
    output ex_pkg::alu_mode_t           alu_mode,
    output ex_pkg::res_kind_t           d_kind,
    output logic [11:0]                 d_csr_addr
);

    localparam int xl = ex_pkg::xlen;
    localparam int ww = ex_pkg::word_width;

    logic [xl-1:0] lo_zext;
    logic [xl-1:0] lo_high;
    logic [xl-1:0] sh_reg;
    logic [xl-1:0] sh_imm;
    logic [xl-1:0] shw_reg;
    logic [xl-1:0] shw_imm;
    logic [xl-1:0] a_nxt;
    logic [xl-1:0] b_nxt;
    ex_pkg::alu_mode_t mode_nxt;
    ex_pkg::res_kind_t kind_nxt;

    // low word, zero-extended or moved to the upper half for sraw
    assign lo_zext = {{(xl - ww){1'b0}}, in_src_a[ww-1:0]};
    assign lo_high = {in_src_a[ww-1:0], {(xl - ww){1'b0}}};
    // masked shift amounts
    assign sh_reg = {{(xl - ex_pkg::shamt_width){1'b0}}, in_src_b[ex_pkg::shamt_width-1:0]};
    assign sh_imm = {{(xl - ex_pkg::shamt_width){1'b0}}, in_imm[ex_pkg::shamt_width-1:0]};
    assign shw_reg = {{(xl - ex_pkg::shamt_word_width){1'b0}},
                      in_src_b[ex_pkg::shamt_word_width-1:0]};
    assign shw_imm = {{(xl - ex_pkg::shamt_word_width){1'b0}},
                      in_imm[ex_pkg::shamt_word_width-1:0]};

    // operand a
    always_comb begin
        case (in_op)
            ex_pkg::op_lui: a_nxt = '0;
            ex_pkg::op_auipc, ex_pkg::op_jal: a_nxt = in_pc;
            ex_pkg::op_slliw, ex_pkg::op_srliw, ex_pkg::op_srlw: a_nxt = lo_zext;
            ex_pkg::op_sraiw, ex_pkg::op_sraw: a_nxt = lo_high;
            default: a_nxt = in_src_a;
        endcase
    end

    // operand b
    always_comb begin
        case (in_op)
            ex_pkg::op_sll, ex_pkg::op_srl: b_nxt = sh_reg;
            ex_pkg::op_slli, ex_pkg::op_srli, ex_pkg::op_srai: b_nxt = sh_imm;
            ex_pkg::op_slliw, ex_pkg::op_srliw, ex_pkg::op_sraiw: b_nxt = shw_imm;
            ex_pkg::op_sllw, ex_pkg::op_srlw, ex_pkg::op_sraw: b_nxt = shw_reg;
            ex_pkg::op_addi, ex_pkg::op_slti, ex_pkg::op_sltiu, ex_pkg::op_xori,
            ex_pkg::op_ori, ex_pkg::op_andi, ex_pkg::op_addiw,
            ex_pkg::op_lui, ex_pkg::op_auipc, ex_pkg::op_jal, ex_pkg::op_jalr:
                b_nxt = in_imm;
            default: b_nxt = in_src_b;
        endcase
    end

    // alu function, add unless listed
    always_comb begin
        case (in_op)
            ex_pkg::op_sub, ex_pkg::op_subw, ex_pkg::op_beq, ex_pkg::op_bne:
                mode_nxt = ex_pkg::alu_sub;
            ex_pkg::op_slt, ex_pkg::op_slti, ex_pkg::op_blt, ex_pkg::op_bge:
                mode_nxt = ex_pkg::alu_slt;
            ex_pkg::op_sltu, ex_pkg::op_sltiu, ex_pkg::op_bltu, ex_pkg::op_bgeu:
                mode_nxt = ex_pkg::alu_sltu;
            ex_pkg::op_xor, ex_pkg::op_xori: mode_nxt = ex_pkg::alu_xor;
            // csrrs sets bits, so an or of rs1 and the old csr
            ex_pkg::op_or, ex_pkg::op_ori, ex_pkg::op_csrrs: mode_nxt = ex_pkg::alu_or;
            ex_pkg::op_and, ex_pkg::op_andi: mode_nxt = ex_pkg::alu_and;
            ex_pkg::op_sll, ex_pkg::op_slli, ex_pkg::op_slliw, ex_pkg::op_sllw:
                mode_nxt = ex_pkg::alu_sll;
            ex_pkg::op_srl, ex_pkg::op_srli, ex_pkg::op_srliw, ex_pkg::op_srlw:
                mode_nxt = ex_pkg::alu_srl;
            ex_pkg::op_srai, ex_pkg::op_sraiw, ex_pkg::op_sraw:
                mode_nxt = ex_pkg::alu_sra;
            default: mode_nxt = ex_pkg::alu_add;
        endcase
    end

    // result kind, the only op test the result step sees
    always_comb begin
        case (in_op)
            ex_pkg::op_add, ex_pkg::op_sub, ex_pkg::op_sll, ex_pkg::op_slt,
            ex_pkg::op_sltu, ex_pkg::op_xor, ex_pkg::op_srl, ex_pkg::op_or,
            ex_pkg::op_and, ex_pkg::op_addi, ex_pkg::op_slti, ex_pkg::op_sltiu,
            ex_pkg::op_xori, ex_pkg::op_ori, ex_pkg::op_andi, ex_pkg::op_slli,
            ex_pkg::op_srli, ex_pkg::op_srai, ex_pkg::op_lui, ex_pkg::op_auipc:
                kind_nxt = ex_pkg::rk_alu;
            ex_pkg::op_addiw, ex_pkg::op_slliw, ex_pkg::op_srliw, ex_pkg::op_addw,
            ex_pkg::op_subw, ex_pkg::op_sllw, ex_pkg::op_srlw:
                kind_nxt = ex_pkg::rk_word_lo;
            ex_pkg::op_sraiw, ex_pkg::op_sraw: kind_nxt = ex_pkg::rk_word_hi;
            ex_pkg::op_jal: kind_nxt = ex_pkg::rk_jal;
            ex_pkg::op_jalr: kind_nxt = ex_pkg::rk_jalr;
            ex_pkg::op_beq: kind_nxt = ex_pkg::rk_beq;
            ex_pkg::op_bne: kind_nxt = ex_pkg::rk_bne;
            ex_pkg::op_blt, ex_pkg::op_bltu: kind_nxt = ex_pkg::rk_blt;
            ex_pkg::op_bge, ex_pkg::op_bgeu: kind_nxt = ex_pkg::rk_bge;
            ex_pkg::op_csrrw: kind_nxt = ex_pkg::rk_csrrw;
            ex_pkg::op_csrrs: kind_nxt = ex_pkg::rk_csrrs;
            ex_pkg::op_ecall: kind_nxt = ex_pkg::rk_ecall;
            ex_pkg::op_mret: kind_nxt = ex_pkg::rk_mret;
            default: kind_nxt = ex_pkg::rk_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
            d_kind <= ex_pkg::rk_none;
        end else begin
            d_valid <= in_valid;
            d_kind <= in_valid ? kind_nxt : ex_pkg::rk_none;
        end
    end

    // payload zeroed between strobes
    always_ff @(posedge clk) begin
        d_pc <= in_valid ? in_pc : '0;
        d_src_a <= in_valid ? in_src_a : '0;
        d_imm <= in_valid ? in_imm : '0;
        alu_a <= in_valid ? a_nxt : '0;
        alu_b <= in_valid ? b_nxt : '0;
        alu_mode <= in_valid ? mode_nxt : ex_pkg::alu_add;
        // csr address rides in the low immediate bits
        d_csr_addr <= in_valid ? in_imm[11:0] : 12'h000;
    end

endmodule

//--- ex_result.sv
`timescale 1ns/100ps

module ex_result (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        d_valid,
    input  logic [ex_pkg::xlen-1:0]     d_pc,
    input  logic [ex_pkg::xlen-1:0]     d_src_a,
    input  logic [ex_pkg::xlen-1:0]     d_imm,
    input  ex_pkg::res_kind_t           d_kind,
    input  logic [11:0]                 d_csr_addr,
    input  logic [ex_pkg::xlen-1:0]     alu_y,
    output logic                        out_valid,
    output logic [ex_pkg::xlen-1:0]     out_pc,
    output logic [ex_pkg::xlen-1:0]     alu_result,
    output logic                        pc_update,
    output logic [ex_pkg::xlen-1:0]     dnpc,
    output logic                        wen_mtvec,
    output logic                        wen_mepc,
    output logic                        wen_mcause,
    output logic                        wen_mstatus,
    output logic [ex_pkg::xlen-1:0]     wdata_mtvec,
    output logic [ex_pkg::xlen-1:0]     wdata_mepc,
    output logic [ex_pkg::xlen-1:0]     wdata_mcause,
    output logic [ex_pkg::xlen-1:0]     wdata_mstatus
);

    localparam int xl = ex_pkg::xlen;
    localparam int ww = ex_pkg::word_width;

    logic [xl-1:0] snpc;
    logic [xl-1:0] target;
    logic taken;
    logic [xl-1:0] res_nxt;
    logic [xl-1:0] npc_nxt;
    logic upd_nxt;
    logic csr_wr;
    logic [xl-1:0] csr_data;
    logic is_ecall;
    logic mtvec_nxt;
    logic mepc_nxt;
    logic mcause_nxt;
    logic mstatus_nxt;

    assign snpc = d_pc + ex_pkg::inst_bytes;
    assign target = d_pc + d_imm;

    // branch decision from the alu difference or compare bit
    always_comb begin
        case (d_kind)
            ex_pkg::rk_beq: taken = alu_y == '0;
            ex_pkg::rk_bne: taken = alu_y != '0;
            ex_pkg::rk_blt: taken = alu_y[0];
            ex_pkg::rk_bge: taken = !alu_y[0];
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (d_kind)
            ex_pkg::rk_alu, ex_pkg::rk_beq, ex_pkg::rk_bne, ex_pkg::rk_blt, ex_pkg::rk_bge:
                res_nxt = alu_y;
            ex_pkg::rk_word_lo: res_nxt = {{(xl - ww){alu_y[ww-1]}}, alu_y[ww-1:0]};
            ex_pkg::rk_word_hi: res_nxt = {{(xl - ww){alu_y[xl-1]}}, alu_y[xl-1:xl-ww]};
            // link value
            ex_pkg::rk_jal, ex_pkg::rk_jalr: res_nxt = snpc;
            // csr, trap and idle slots write no register
            default: res_nxt = '0;
        endcase
    end

    // next pc, sequential for any other valid op
    always_comb begin
        upd_nxt = 1'b1;
        case (d_kind)
            ex_pkg::rk_jal: npc_nxt = alu_y;
            ex_pkg::rk_jalr: npc_nxt = {alu_y[xl-1:1], 1'b0};
            ex_pkg::rk_beq, ex_pkg::rk_bne, ex_pkg::rk_blt, ex_pkg::rk_bge:
                npc_nxt = taken ? target : snpc;
            // mtvec on ecall, mepc on mret, both carried in src_a
            ex_pkg::rk_ecall, ex_pkg::rk_mret: npc_nxt = d_src_a;
            default: begin
                upd_nxt = 1'b0;
                npc_nxt = d_valid ? snpc : '0;
            end
        endcase
    end

    // csr writes
    assign csr_wr = d_kind == ex_pkg::rk_csrrw || d_kind == ex_pkg::rk_csrrs;
    assign csr_data = d_kind == ex_pkg::rk_csrrw ? d_src_a : alu_y;
    assign is_ecall = d_kind == ex_pkg::rk_ecall;
    // mtvec takes csrrw only
    assign mtvec_nxt = d_kind == ex_pkg::rk_csrrw && d_csr_addr == ex_pkg::csr_mtvec;
    assign mepc_nxt = (csr_wr && d_csr_addr == ex_pkg::csr_mepc) || is_ecall;
    assign mcause_nxt = (csr_wr && d_csr_addr == ex_pkg::csr_mcause) || is_ecall;
    assign mstatus_nxt = csr_wr && d_csr_addr == ex_pkg::csr_mstatus;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            pc_update <= 1'b0;
            wen_mtvec <= 1'b0;
            wen_mepc <= 1'b0;
            wen_mcause <= 1'b0;
            wen_mstatus <= 1'b0;
        end else begin
            out_valid <= d_valid;
            pc_update <= upd_nxt;
            wen_mtvec <= mtvec_nxt;
            wen_mepc <= mepc_nxt;
            wen_mcause <= mcause_nxt;
            wen_mstatus <= mstatus_nxt;
        end
    end

    // data is already zero when d_valid is low
    always_ff @(posedge clk) begin
        out_pc <= d_pc;
        alu_result <= res_nxt;
        dnpc <= npc_nxt;
        wdata_mtvec <= mtvec_nxt ? csr_data : '0;
        wdata_mepc <= !mepc_nxt ? '0 : is_ecall ? d_pc : csr_data;
        wdata_mcause <= !mcause_nxt ? '0 : is_ecall ? ex_pkg::cause_ecall : csr_data;
        wdata_mstatus <= mstatus_nxt ? csr_data : '0;
    end

endmodule

//--- ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic [ex_pkg::xlen-1:0]     in_pc,
    input  ex_pkg::op_code_t            in_op,
    input  logic [ex_pkg::xlen-1:0]     in_src_a,
    input  logic [ex_pkg::xlen-1:0]     in_src_b,
    input  logic [ex_pkg::xlen-1:0]     in_imm,
    output logic                        out_valid,
    output logic [ex_pkg::xlen-1:0]     out_pc,
    output logic [ex_pkg::xlen-1:0]     alu_result,
    output logic                        pc_update,
    output logic [ex_pkg::xlen-1:0]     dnpc,
    output logic                        wen_mtvec,
    output logic                        wen_mepc,
    output logic                        wen_mcause,
    output logic                        wen_mstatus,
    output logic [ex_pkg::xlen-1:0]     wdata_mtvec,
    output logic [ex_pkg::xlen-1:0]     wdata_mepc,
    output logic [ex_pkg::xlen-1:0]     wdata_mcause,
    output logic [ex_pkg::xlen-1:0]     wdata_mstatus
);

    // decode register outputs
    logic d_valid;
    logic [ex_pkg::xlen-1:0] d_pc;
    logic [ex_pkg::xlen-1:0] d_src_a;
    logic [ex_pkg::xlen-1:0] d_imm;
    logic [ex_pkg::xlen-1:0] alu_a;
    logic [ex_pkg::xlen-1:0] alu_b;
    ex_pkg::alu_mode_t alu_mode;
    ex_pkg::res_kind_t d_kind;
    logic [11:0] d_csr_addr;
    // alu output, same cycle as decode registers
    logic [ex_pkg::xlen-1:0] alu_y;

    ex_decode u_decode (
        .clk, .rst, .in_valid, .in_pc, .in_op, .in_src_a, .in_src_b, .in_imm,
        .d_valid, .d_pc, .d_src_a, .d_imm, .alu_a, .alu_b, .alu_mode,
        .d_kind, .d_csr_addr
    );

    ex_alu u_alu (
        .alu_a, .alu_b, .alu_mode, .alu_y
    );

    ex_result u_result (
        .clk, .rst, .d_valid, .d_pc, .d_src_a, .d_imm, .d_kind, .d_csr_addr, .alu_y,
        .out_valid, .out_pc, .alu_result, .pc_update, .dnpc,
        .wen_mtvec, .wen_mepc, .wen_mcause, .wen_mstatus,
        .wdata_mtvec, .wdata_mepc, .wdata_mcause, .wdata_mstatus
    );

endmodule

//--- ex_stage_checker.sv
`timescale 1ns/100ps

module ex_stage_checker (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  logic    out_valid,
    input  logic    pc_update,
    input  logic    wen_mtvec,
    input  logic    wen_mepc,
    input  logic    wen_mcause,
    input  logic    wen_mstatus
);

    // set once a strobe has gone in since reset
    logic strobe_seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            strobe_seen <= 1'b0;
        end else if (in_valid) begin
            strobe_seen <= 1'b1;
        end
    end

    // side effects only on a valid slot
    flags_need_valid: assert property (@(posedge clk) disable iff (rst)
        (pc_update || wen_mtvec || wen_mepc || wen_mcause || wen_mstatus) |-> out_valid)
        else $error("pc_update or a csr enable high without out_valid");

    // fixed two-cycle latency
    two_cycle_latency: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two cycles");

    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !strobe_seen |-> !out_valid)
        else $error("out_valid high before any strobe");

endmodule

bind ex_stage ex_stage_checker u_checker (
    .clk, .rst, .in_valid, .out_valid, .pc_update,
    .wen_mtvec, .wen_mepc, .wen_mcause, .wen_mstatus
);

//--- tb_ex_stage.sv
`timescale 1ns/100ps

module tb_ex_stage;

    // one expected result, due on a given monitor cycle
    typedef struct packed {
        int          due;
        logic [63:0] pc;
        logic [63:0] res;
        logic        upd;
        logic [63:0] npc;
        logic [3:0]  wen;
        logic [63:0] wd_tvec;
        logic [63:0] wd_epc;
        logic [63:0] wd_cause;
        logic [63:0] wd_status;
    } expect_t;

    logic clk = 1'b0;
    logic rst;
    logic in_valid;
    logic [63:0] in_pc;
    ex_pkg::op_code_t in_op;
    logic [63:0] in_src_a;
    logic [63:0] in_src_b;
    logic [63:0] in_imm;
    logic out_valid;
    logic [63:0] out_pc;
    logic [63:0] alu_result;
    logic pc_update;
    logic [63:0] dnpc;
    logic wen_mtvec;
    logic wen_mepc;
    logic wen_mcause;
    logic wen_mstatus;
    logic [63:0] wdata_mtvec;
    logic [63:0] wdata_mepc;
    logic [63:0] wdata_mcause;
    logic [63:0] wdata_mstatus;

    integer seed = 32'hfa1f_4edb;
    // negedge count, written only by the monitor
    int cyc = 0;
    expect_t exp_q[$];

    ex_pkg::op_code_t int_ops [20] = '{
        ex_pkg::op_add, ex_pkg::op_sub, ex_pkg::op_sll, ex_pkg::op_slt, ex_pkg::op_sltu,
        ex_pkg::op_xor, ex_pkg::op_srl, ex_pkg::op_or, ex_pkg::op_and, ex_pkg::op_addi,
        ex_pkg::op_slti, ex_pkg::op_sltiu, ex_pkg::op_xori, ex_pkg::op_ori, ex_pkg::op_andi,
        ex_pkg::op_slli, ex_pkg::op_srli, ex_pkg::op_srai, ex_pkg::op_lui, ex_pkg::op_auipc
    };
    ex_pkg::op_code_t word_ops [9] = '{
        ex_pkg::op_addiw, ex_pkg::op_slliw, ex_pkg::op_srliw, ex_pkg::op_sraiw,
        ex_pkg::op_addw, ex_pkg::op_subw, ex_pkg::op_sllw, ex_pkg::op_srlw, ex_pkg::op_sraw
    };
    ex_pkg::op_code_t br_ops [6] = '{
        ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt,
        ex_pkg::op_bge, ex_pkg::op_bltu, ex_pkg::op_bgeu
    };
    ex_pkg::op_code_t mix_ops [12] = '{
        ex_pkg::op_add, ex_pkg::op_srai, ex_pkg::op_addw, ex_pkg::op_sraiw,
        ex_pkg::op_subw, ex_pkg::op_beq, ex_pkg::op_bltu, ex_pkg::op_jal,
        ex_pkg::op_jalr, ex_pkg::op_csrrs, ex_pkg::op_ecall, ex_pkg::op_mret
    };
    // equal, signed less but unsigned greater, both less
    logic [63:0] br_a [3] = '{64'd5, 64'hffff_ffff_ffff_fffd, 64'd2};
    logic [63:0] br_b [3] = '{64'd5, 64'd7, 64'd9};
    logic [11:0] csr_list [5] = '{12'h305, 12'h341, 12'h342, 12'h300, 12'h123};

    ex_stage dut (.*);

    always #4 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else
            fail_run($sformatf("error at %0t: %s expected %h, got %h", $time, name, exp, act));
    endtask

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // reference model from the riscv rules
    function automatic expect_t model_result(input ex_pkg::op_code_t op, input logic [63:0] pc,
                                             input logic [63:0] a, input logic [63:0] b,
                                             input logic [63:0] imm);
        expect_t e;
        logic [63:0] d;
        logic [11:0] csr;
        logic lt_s;
        logic lt_u;
        logic taken;
        e = '0;
        e.pc = pc;
        csr = imm[11:0];
        lt_s = $signed(a) < $signed(b);
        lt_u = a < b;
        case (op)
            ex_pkg::op_add: e.res = a + b;
            ex_pkg::op_sub: e.res = a - b;
            ex_pkg::op_sll: e.res = a << b[5:0];
            ex_pkg::op_slt: e.res = {63'd0, lt_s};
            ex_pkg::op_sltu: e.res = {63'd0, lt_u};
            ex_pkg::op_xor: e.res = a ^ b;
            ex_pkg::op_srl: e.res = a >> b[5:0];
            ex_pkg::op_or: e.res = a | b;
            ex_pkg::op_and: e.res = a & b;
            ex_pkg::op_addi: e.res = a + imm;
            ex_pkg::op_slti: e.res = {63'd0, $signed(a) < $signed(imm)};
            ex_pkg::op_sltiu: e.res = {63'd0, a < imm};
            ex_pkg::op_xori: e.res = a ^ imm;
            ex_pkg::op_ori: e.res = a | imm;
            ex_pkg::op_andi: e.res = a & imm;
            ex_pkg::op_slli: e.res = a << imm[5:0];
            ex_pkg::op_srli: e.res = a >> imm[5:0];
            ex_pkg::op_srai: e.res = $signed(a) >>> imm[5:0];
            ex_pkg::op_lui: e.res = imm;
            ex_pkg::op_auipc: e.res = pc + imm;
            // 32-bit result, then sign-extended
            ex_pkg::op_addiw: e.res = sext32(a[31:0] + imm[31:0]);
            ex_pkg::op_slliw: e.res = sext32(a[31:0] << imm[4:0]);
            ex_pkg::op_srliw: e.res = sext32(a[31:0] >> imm[4:0]);
            ex_pkg::op_sraiw: e.res = sext32($signed(a[31:0]) >>> imm[4:0]);
            ex_pkg::op_addw: e.res = sext32(a[31:0] + b[31:0]);
            ex_pkg::op_subw: e.res = sext32(a[31:0] - b[31:0]);
            ex_pkg::op_sllw: e.res = sext32(a[31:0] << b[4:0]);
            ex_pkg::op_srlw: e.res = sext32(a[31:0] >> b[4:0]);
            ex_pkg::op_sraw: e.res = sext32($signed(a[31:0]) >>> b[4:0]);
            // branch result is the raw difference or compare bit
            ex_pkg::op_beq, ex_pkg::op_bne: e.res = a - b;
            ex_pkg::op_blt, ex_pkg::op_bge: e.res = {63'd0, lt_s};
            ex_pkg::op_bltu, ex_pkg::op_bgeu: e.res = {63'd0, lt_u};
            ex_pkg::op_jal: begin
                e.res = pc + 64'd4;
                e.upd = 1'b1;
                e.npc = pc + imm;
            end
            ex_pkg::op_jalr: begin
                e.res = pc + 64'd4;
                e.upd = 1'b1;
                e.npc = (a + imm) & ~64'd1;
            end
            ex_pkg::op_csrrw, ex_pkg::op_csrrs: begin
                // csrrs never writes mtvec
                d = (op == ex_pkg::op_csrrw) ? a : (a | b);
                e.wen = {csr == 12'h305 && op == ex_pkg::op_csrrw, csr == 12'h341,
                         csr == 12'h342, csr == 12'h300};
                e.wd_tvec = e.wen[3] ? d : 64'd0;
                e.wd_epc = e.wen[2] ? d : 64'd0;
                e.wd_cause = e.wen[1] ? d : 64'd0;
                e.wd_status = e.wen[0] ? d : 64'd0;
            end
            ex_pkg::op_ecall: begin
                e.upd = 1'b1;
                e.npc = a;
                e.wen = 4'b0110;
                e.wd_epc = pc;
                e.wd_cause = 64'd11;
            end
            ex_pkg::op_mret: begin
                e.upd = 1'b1;
                e.npc = a;
            end
            default: e.res = 64'd0;
        endcase
        case (op)
            ex_pkg::op_beq: taken = a == b;
            ex_pkg::op_bne: taken = a != b;
            ex_pkg::op_blt: taken = lt_s;
            ex_pkg::op_bge: taken = !lt_s;
            ex_pkg::op_bltu: taken = lt_u;
            ex_pkg::op_bgeu: taken = !lt_u;
            default: taken = 1'b0;
        endcase
        if (op inside {ex_pkg::op_beq, ex_pkg::op_bne, ex_pkg::op_blt,
                       ex_pkg::op_bge, ex_pkg::op_bltu, ex_pkg::op_bgeu}) begin
            e.upd = 1'b1;
            e.npc = taken ? pc + imm : pc + 64'd4;
        end
        return e;
    endfunction

    // one strobe, result due two cycles later
    task automatic send(input ex_pkg::op_code_t op, input logic [63:0] pc,
                        input logic [63:0] a, input logic [63:0] b, input logic [63:0] imm);
        expect_t e;
        @(posedge clk);
        in_valid <= 1'b1;
        in_op <= op;
        in_pc <= pc;
        in_src_a <= a;
        in_src_b <= b;
        in_imm <= imm;
        e = model_result(op, pc, a, b, imm);
        e.due = cyc + 2;
        exp_q.push_back(e);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
            fail_run("timeout: results still missing 10 cycles after the last strobe");
    endtask

    // compares every output against the queue head on its due cycle
    task automatic check_outputs();
        expect_t head;
        logic due_now;
        head = '0;
        if (exp_q.size() != 0)
            head = exp_q[0];
        due_now = exp_q.size() != 0 && head.due == cyc;
        check_value("out_valid", 64'(due_now), 64'(out_valid));
        if (out_valid) begin
            void'(exp_q.pop_front());
            check_value("out_pc", head.pc, out_pc);
            check_value("alu_result", head.res, alu_result);
            check_value("pc_update", 64'(head.upd), 64'(pc_update));
            if (head.upd)
                check_value("dnpc", head.npc, dnpc);
            check_value("wen", 64'(head.wen),
                        64'({wen_mtvec, wen_mepc, wen_mcause, wen_mstatus}));
            check_value("wdata_mtvec", head.wd_tvec, wdata_mtvec);
            check_value("wdata_mepc", head.wd_epc, wdata_mepc);
            check_value("wdata_mcause", head.wd_cause, wdata_mcause);
            check_value("wdata_mstatus", head.wd_status, wdata_mstatus);
        end else begin
            check_value("idle flags", 64'd0,
                        64'({pc_update, wen_mtvec, wen_mepc, wen_mcause, wen_mstatus}));
            check_value("idle data", 64'd0, out_pc | alu_result | dnpc | wdata_mtvec |
                        wdata_mepc | wdata_mcause | wdata_mstatus);
        end
    endtask

    always @(negedge clk) begin
        if (!rst)
            check_outputs();
        cyc = cyc + 1;
    end

    task automatic run_reset_test();
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_value("out_valid", 64'd0, 64'(out_valid));
        check_value("pc_update", 64'd0, 64'(pc_update));
        check_value("wen", 64'd0, 64'({wen_mtvec, wen_mepc, wen_mcause, wen_mstatus}));
    endtask

    task automatic run_integer_test();
        foreach (int_ops[i]) begin
            send(int_ops[i], rand64() & ~64'd3, rand64(), rand64(), rand64());
            drain();
        end
    endtask

    task automatic run_word_test();
        foreach (word_ops[i]) begin
            send(word_ops[i], rand64() & ~64'd3, rand64(), rand64(), rand64());
            drain();
        end
        // negative word sum, and a shift with junk in the upper half
        send(ex_pkg::op_addw, 64'h100, 64'hffff_0000_7fff_ffff, 64'd1, 64'd0);
        send(ex_pkg::op_sraw, 64'h104, 64'h1234_5678_8000_0000, 64'd4, 64'd0);
        send(ex_pkg::op_srliw, 64'h108, 64'hdead_beef_f000_0000, 64'd0, 64'd28);
        drain();
    endtask

    task automatic run_branch_test();
        foreach (br_ops[i]) begin
            for (int p = 0; p < 3; p++) begin
                send(br_ops[i], rand64() & ~64'd3, br_a[p], br_b[p], rand64());
                drain();
            end
        end
        send(ex_pkg::op_jal, 64'h8000_0000, rand64(), rand64(), 64'h7fc);
        drain();
        // odd target, bit 0 must drop
        send(ex_pkg::op_jalr, 64'h8000_0010, rand64() | 64'd1, rand64(), 64'h10);
        drain();
    endtask

    task automatic run_csr_test();
        foreach (csr_list[i]) begin
            send(ex_pkg::op_csrrw, rand64() & ~64'd3, rand64(), rand64(), {52'd0, csr_list[i]});
            drain();
            send(ex_pkg::op_csrrs, rand64() & ~64'd3, rand64(), rand64(), {52'd0, csr_list[i]});
            drain();
        end
        send(ex_pkg::op_ecall, 64'h8000_0200, rand64(), rand64(), 64'd0);
        drain();
        send(ex_pkg::op_mret, 64'h8000_0300, rand64(), rand64(), 64'd0);
        drain();
    endtask

    task automatic run_burst_test();
        int idx;
        for (int k = 0; k < 16; k++) begin
            idx = $unsigned($random(seed)) % 12;
            send(mix_ops[idx], rand64() & ~64'd3, rand64(), rand64(), rand64());
        end
        drain();
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_pc = '0;
        in_op = '0;
        in_src_a = '0;
        in_src_b = '0;
        in_imm = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        run_reset_test();
        run_integer_test();
        run_word_test();
        run_branch_test();
        run_csr_test();
        run_burst_test();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- filelist.f
ex_pkg.sv
ex_alu.sv
ex_decode.sv
ex_result.sv
ex_stage.sv
ex_stage_checker.sv
tb_ex_stage.sv

//--- Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_stage
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --assert --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: build run clean

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
